//--- design/la_core_params.svh
`ifndef LA_CORE_PARAMS_SVH
`define LA_CORE_PARAMS_SVH

// first fetch address after reset
`define LA_RESET_PC     32'h1c00_0000

// the data RAM depth in 32-bit words must be a power of two
`define LA_DMEM_WORDS   256

`endif

//--- design/la_core_pkg.sv
`default_nettype none

package la_core_pkg;

// one-hot ALU select with each bit position named below
typedef logic [11:0] alu_op_t;

localparam int ALU_ADD  = 0;
localparam int ALU_SUB  = 1;
localparam int ALU_SLT  = 2;
localparam int ALU_SLTU = 3;
localparam int ALU_AND  = 4;
localparam int ALU_NOR  = 5;
localparam int ALU_OR   = 6;
localparam int ALU_XOR  = 7;
localparam int ALU_SLL  = 8;
localparam int ALU_SRL  = 9;
localparam int ALU_SRA  = 10;
localparam int ALU_LUI  = 11;

typedef struct packed {
        logic           valid;
        logic           predict;
        logic [31:0]    inst;
        logic [31:0]    pc;
} if_id_t;

typedef struct packed {
        logic           valid;
        logic [31:0]    pc;
        logic [31:0]    inst;
        logic [31:0]    src1;
        logic [31:0]    src2;
        alu_op_t        alu_op;
        logic           is_load;
        logic           mem_we;
        logic           res_from_mem;
        logic           gr_we;
        logic [31:0]    st_data;
        logic [4:0]     dest;
} id_ex_t;

typedef struct packed {
        logic           valid;
        logic [31:0]    pc;
        logic [31:0]    result;         // ALU result that doubles as the load/store address
        logic           is_load;
        logic           mem_we;
        logic           gr_we;
        logic [31:0]    st_data;
        logic [4:0]     dest;
} ex_mem_t;

typedef struct packed {
        logic           valid;
        logic [31:0]    pc;
        logic           gr_we;
        logic [4:0]     dest;
        logic [31:0]    result;
} mem_wb_t;

// one bypass source into decode
typedef struct packed {
        logic           valid;
        logic [4:0]     addr;
        logic [31:0]    data;
} fwd_t;

typedef struct packed {
        logic [31:0]    pc;
        logic [4:0]     dest;
        logic [31:0]    data;
        logic           we;
} retire_t;

endpackage

`default_nettype wire

//--- design/fetch_stage.sv
`include "la_core_params.svh"
`default_nettype none

module fetch_stage import la_core_pkg::*; (
        input  wire             clk,
        input  wire             rst,
        input  wire             id_allowin,
        input  wire             flush,
        input  wire     [31:0]  pc_real,
        output logic    [31:0]  inst_addr,
        input  wire     [31:0]  inst_rdata,
        output if_id_t          if_to_id
);

logic [31:0]    pc;

assign inst_addr = pc;          // memory answers combinationally

always_ff @(posedge clk) begin
        if (rst) begin
                pc <= `LA_RESET_PC;
        end else if (flush) begin
                pc <= pc_real;
        end else if (id_allowin) begin
                pc <= pc + 32'd4;
        end
end

// on flush the word fetched down the wrong path is dropped here
always_ff @(posedge clk) begin
        if (rst || flush) begin
                if_to_id.valid <= 1'b0;
        end else if (id_allowin) begin
                if_to_id <= '{valid: 1'b1, predict: 1'b0, inst: inst_rdata, pc: pc};
        end
end

// pc_real comes from decode, so this also covers branch and jirl targets
assert property (@(posedge clk) disable iff (rst) inst_addr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", inst_addr);

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage import la_core_pkg::*; (
        input  wire             clk,
        input  wire             rst,
        input  wire             ex_allowin,
        input  wire if_id_t     if_to_id,
        input  wire             mem_done,
        input  wire     [31:0]  done_pc,
        input  wire     [31:0]  load_data,
        input  wire fwd_t       ex_fwd,
        input  wire fwd_t       mem_fwd,
        input  wire     [31:0]  rf_rdata1,
        input  wire     [31:0]  rf_rdata2,
        output logic            id_allowin,
        output logic    [4:0]   rf_raddr1,
        output logic    [4:0]   rf_raddr2,
        output logic            flush,
        output logic    [31:0]  pc_real,
        output id_ex_t          id_to_ex
);

logic           valid;
logic [31:0]    inst;
logic [31:0]    pc;
logic [4:0]     rd, rj, rk;

logic           inst_add_w, inst_sub_w, inst_slt, inst_sltu;
logic           inst_nor, inst_and, inst_or, inst_xor;
logic           inst_slli_w, inst_srli_w, inst_srai_w;
logic           inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
logic           inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;

alu_op_t        alu_op;
logic           src1_is_pc, src2_is_imm, src2_is_4, src_reg_is_rd;
logic           gr_we;
logic [4:0]     dest;
logic [31:0]    imm, br_offs, jirl_offs;

logic           ld_pend;        // last issued instruction was a load not yet completed
logic [4:0]     ld_dest;
logic [31:0]    ld_pc;
logic           ld_hit, ld_done, readygo;
logic [31:0]    rj_value, rkd_value;
logic           br_taken;
logic [31:0]    br_target;

assign valid = if_to_id.valid;
assign inst  = if_to_id.inst;
assign pc    = if_to_id.pc;
assign rd    = inst[4:0];
assign rj    = inst[9:5];
assign rk    = inst[14:10];

// ----------------------------------------------------------------------
// opcode match
// ----------------------------------------------------------------------
assign inst_add_w   = inst[31:15] == 17'h00020;
assign inst_sub_w   = inst[31:15] == 17'h00022;
assign inst_slt     = inst[31:15] == 17'h00024;
assign inst_sltu    = inst[31:15] == 17'h00025;
assign inst_nor     = inst[31:15] == 17'h00028;
assign inst_and     = inst[31:15] == 17'h00029;
assign inst_or      = inst[31:15] == 17'h0002a;
assign inst_xor     = inst[31:15] == 17'h0002b;
assign inst_slli_w  = inst[31:15] == 17'h00081;
assign inst_srli_w  = inst[31:15] == 17'h00089;
assign inst_srai_w  = inst[31:15] == 17'h00091;
assign inst_addi_w  = inst[31:22] == 10'h00a;
assign inst_ld_w    = inst[31:22] == 10'h0a2;
assign inst_st_w    = inst[31:22] == 10'h0a6;
assign inst_lu12i_w = inst[31:25] == 7'h0a;
assign inst_jirl    = inst[31:26] == 6'h13;
assign inst_b       = inst[31:26] == 6'h14;
assign inst_bl      = inst[31:26] == 6'h15;
assign inst_beq     = inst[31:26] == 6'h16;
assign inst_bne     = inst[31:26] == 6'h17;

// branches without a link still carry the add select so alu_op stays one-hot
assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | inst_jirl
                        | inst_bl | inst_b | inst_beq | inst_bne;
assign alu_op[ALU_SUB]  = inst_sub_w;
assign alu_op[ALU_SLT]  = inst_slt;
assign alu_op[ALU_SLTU] = inst_sltu;
assign alu_op[ALU_AND]  = inst_and;
assign alu_op[ALU_NOR]  = inst_nor;
assign alu_op[ALU_OR]   = inst_or;
assign alu_op[ALU_XOR]  = inst_xor;
assign alu_op[ALU_SLL]  = inst_slli_w;
assign alu_op[ALU_SRL]  = inst_srli_w;
assign alu_op[ALU_SRA]  = inst_srai_w;
assign alu_op[ALU_LUI]  = inst_lu12i_w;

assign src2_is_4     = inst_jirl | inst_bl;     // link value is pc + 4
assign src1_is_pc    = inst_jirl | inst_bl;
assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
assign src2_is_imm   = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_ld_w
                     | inst_st_w | inst_lu12i_w | src2_is_4;
assign gr_we         = ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
assign dest          = inst_bl ? 5'd1 : rd;

assign imm = src2_is_4    ? 32'd4 :
             inst_lu12i_w ? {inst[24:5], 12'd0} :
                            {{20{inst[21]}}, inst[21:10]};  // ui5 sits in the low bits

assign br_offs   = (inst_b | inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00} :
                                        {{14{inst[25]}}, inst[25:10], 2'b00};
assign jirl_offs = {{14{inst[25]}}, inst[25:10], 2'b00};

assign rf_raddr1 = rj;
assign rf_raddr2 = src_reg_is_rd ? rd : rk;

// ----------------------------------------------------------------------
// load-use hazard and bypass
// ----------------------------------------------------------------------
assign ld_hit  = ld_pend & (ld_dest == rf_raddr1 | ld_dest == rf_raddr2);
assign ld_done = ld_pend & mem_done & (done_pc == ld_pc);
assign readygo = ~ld_hit | ld_done;

assign id_allowin = ~valid | readygo & ex_allowin;

assign rj_value  = (rf_raddr1 == 5'd0)                          ? 32'd0 :
                   ld_done & (ld_dest == rf_raddr1)             ? load_data :
                   ex_fwd.valid & (ex_fwd.addr == rf_raddr1)    ? ex_fwd.data :
                   mem_fwd.valid & (mem_fwd.addr == rf_raddr1)  ? mem_fwd.data :
                                                                  rf_rdata1;
assign rkd_value = (rf_raddr2 == 5'd0)                          ? 32'd0 :
                   ld_done & (ld_dest == rf_raddr2)             ? load_data :
                   ex_fwd.valid & (ex_fwd.addr == rf_raddr2)    ? ex_fwd.data :
                   mem_fwd.valid & (mem_fwd.addr == rf_raddr2)  ? mem_fwd.data :
                                                                  rf_rdata2;

assign br_taken  = inst_beq & (rj_value == rkd_value) | inst_bne & (rj_value != rkd_value)
                 | inst_jirl | inst_bl | inst_b;
assign br_target = inst_jirl ? rj_value + jirl_offs : pc + br_offs;

// operands are only trusted once readygo is up
assign flush   = valid & readygo & ((br_taken ^ if_to_id.predict) | inst_jirl);
assign pc_real = flush ? br_target : 32'd0;

always_ff @(posedge clk) begin
        if (rst) begin
                id_to_ex.valid <= 1'b0;
        end else if (ex_allowin) begin
                id_to_ex <= '{
                        valid:          valid & readygo,        // a stall issues a bubble
                        pc:             pc,
                        inst:           inst,
                        src1:           src1_is_pc ? pc : rj_value,
                        src2:           src2_is_imm ? imm : rkd_value,
                        alu_op:         alu_op,
                        is_load:        inst_ld_w,
                        mem_we:         inst_st_w,
                        res_from_mem:   inst_ld_w,
                        gr_we:          gr_we,
                        st_data:        rkd_value,
                        dest:           dest
                };
        end
end

always_ff @(posedge clk) begin
        if (rst) begin
                ld_pend <= 1'b0;
        end else if (valid & readygo & ex_allowin) begin
                ld_pend <= inst_ld_w & (dest != 5'd0);
        end else if (ld_done) begin
                ld_pend <= 1'b0;
        end
end

always_ff @(posedge clk) begin
        if (valid & readygo & ex_allowin) begin
                ld_dest <= dest;
                ld_pc   <= pc;
        end
end

// the redirect must squash exactly the word that fetch is holding
assert property (@(posedge clk) disable iff (rst) flush |-> valid ##1 !if_to_id.valid)
        else $error("flush at pc %h without a squashed fetch slot", pc);

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`default_nettype none

module execute_stage import la_core_pkg::*; (
        input  wire             clk,
        input  wire             rst,
        input  wire id_ex_t     id_to_ex,
        output logic            ex_allowin,
        output fwd_t            ex_fwd,
        output ex_mem_t         ex_to_mem
);

logic [31:0]    src1, src2;
logic [4:0]     sa;
alu_op_t        op;
logic [31:0]    sum, diff, slt_res, sltu_res, sra_res;
logic [31:0]    result;

assign src1 = id_to_ex.src1;
assign src2 = id_to_ex.src2;
assign sa   = src2[4:0];
assign op   = id_to_ex.alu_op;

assign sum      = src1 + src2;
assign diff     = src1 - src2;
assign slt_res  = {31'd0, $signed(src1) < $signed(src2)};
assign sltu_res = {31'd0, src1 < src2};
assign sra_res  = $signed(src1) >>> sa;

assign result = ({32{op[ALU_ADD]}}  & sum)
              | ({32{op[ALU_SUB]}}  & diff)
              | ({32{op[ALU_SLT]}}  & slt_res)
              | ({32{op[ALU_SLTU]}} & sltu_res)
              | ({32{op[ALU_AND]}}  & (src1 & src2))
              | ({32{op[ALU_NOR]}}  & ~(src1 | src2))
              | ({32{op[ALU_OR]}}   & (src1 | src2))
              | ({32{op[ALU_XOR]}}  & (src1 ^ src2))
              | ({32{op[ALU_SLL]}}  & (src1 << sa))
              | ({32{op[ALU_SRL]}}  & (src1 >> sa))
              | ({32{op[ALU_SRA]}}  & sra_res)
              | ({32{op[ALU_LUI]}}  & src2);

assign ex_allowin = 1'b1;       // no back-pressure from memory

// a load's value is not known here, decode stalls on it instead
assign ex_fwd = '{
        valid:  id_to_ex.valid & id_to_ex.gr_we & ~id_to_ex.res_from_mem,
        addr:   id_to_ex.dest,
        data:   result
};

always_ff @(posedge clk) begin
        if (rst) begin
                ex_to_mem.valid <= 1'b0;
        end else begin
                ex_to_mem <= '{
                        valid:   id_to_ex.valid,
                        pc:      id_to_ex.pc,
                        result:  result,
                        is_load: id_to_ex.is_load,
                        mem_we:  id_to_ex.mem_we,
                        gr_we:   id_to_ex.gr_we,
                        st_data: id_to_ex.st_data,
                        dest:    id_to_ex.dest
                };
        end
end

assert property (@(posedge clk) disable iff (rst) id_to_ex.valid |-> $onehot(op))
        else $error("alu_op %b at pc %h is not one-hot", op, id_to_ex.pc);

endmodule

`default_nettype wire

//--- design/memory_stage.sv
`include "la_core_params.svh"
`default_nettype none

module memory_stage import la_core_pkg::*; (
        input  wire             clk,
        input  wire             rst,
        input  wire ex_mem_t    ex_to_mem,
        output fwd_t            mem_fwd,
        output logic            mem_done,
        output logic    [31:0]  done_pc,
        output logic    [31:0]  load_data,
        output mem_wb_t         mem_to_wb
);

localparam int DMEM_AW = $clog2(`LA_DMEM_WORDS);

logic [31:0]            dmem [`LA_DMEM_WORDS];
logic [DMEM_AW-1:0]     widx;
logic [31:0]            result;

// the byte address drops its upper bits to form the word index
assign widx = ex_to_mem.result[DMEM_AW+1:2];

always_ff @(posedge clk) begin
        if (ex_to_mem.valid & ex_to_mem.mem_we) begin
                dmem[widx] <= ex_to_mem.st_data;
        end
end

assign load_data = dmem[widx];
assign mem_done  = ex_to_mem.valid & ex_to_mem.is_load;
assign done_pc   = ex_to_mem.pc;
assign result    = ex_to_mem.is_load ? load_data : ex_to_mem.result;

assign mem_fwd = '{
        valid:  ex_to_mem.valid & ex_to_mem.gr_we,
        addr:   ex_to_mem.dest,
        data:   result
};

always_ff @(posedge clk) begin
        if (rst) begin
                mem_to_wb.valid <= 1'b0;
        end else begin
                mem_to_wb <= '{
                        valid:  ex_to_mem.valid,
                        pc:     ex_to_mem.pc,
                        gr_we:  ex_to_mem.gr_we,
                        dest:   ex_to_mem.dest,
                        result: result
                };
        end
end

endmodule

`default_nettype wire

//--- design/register_file.sv
`default_nettype none

module register_file import la_core_pkg::*; (
        input  wire             clk,
        input  wire     [4:0]   raddr1,
        input  wire     [4:0]   raddr2,
        output logic    [31:0]  rdata1,
        output logic    [31:0]  rdata2,
        input  wire mem_wb_t    wb,
        output logic            retire_valid,
        output retire_t         retire
);

logic [31:0]    regs [32];      // entry 0 is never written
logic           we;

assign we = wb.valid & wb.gr_we & (wb.dest != 5'd0);

always_ff @(posedge clk) begin
        if (we) begin
                regs[wb.dest] <= wb.result;
        end
end

// a read in the writeback cycle sees the value being written
assign rdata1 = (raddr1 == 5'd0)            ? 32'd0 :
                (we && wb.dest == raddr1)   ? wb.result : regs[raddr1];
assign rdata2 = (raddr2 == 5'd0)            ? 32'd0 :
                (we && wb.dest == raddr2)   ? wb.result : regs[raddr2];

always_ff @(posedge clk) begin
        retire_valid <= wb.valid;
        retire       <= '{pc: wb.pc, dest: wb.dest, data: wb.result, we: wb.gr_we};
end

endmodule

`default_nettype wire

//--- design/la_core_top.sv
`default_nettype none

module la_core_top import la_core_pkg::*; (
        input  wire             clk,
        input  wire             rst,
        output wire     [31:0]  inst_addr,
        input  wire     [31:0]  inst_rdata,
        output wire             retire_valid,
        output wire retire_t    retire
);

wire            id_allowin;
wire            ex_allowin;
wire            flush;
wire [31:0]     pc_real;
wire [4:0]      rf_raddr1, rf_raddr2;
wire [31:0]     rf_rdata1, rf_rdata2;
wire            mem_done;
wire [31:0]     done_pc;
wire [31:0]     load_data;
wire fwd_t      ex_fwd, mem_fwd;
wire if_id_t    if_to_id;
wire id_ex_t    id_to_ex;
wire ex_mem_t   ex_to_mem;
wire mem_wb_t   mem_to_wb;

fetch_stage u_fetch (
        .clk, .rst,
        .id_allowin, .flush, .pc_real,
        .inst_addr, .inst_rdata,
        .if_to_id
);

decode_stage u_decode (
        .clk, .rst,
        .ex_allowin, .if_to_id,
        .mem_done, .done_pc, .load_data,
        .ex_fwd, .mem_fwd,
        .rf_rdata1, .rf_rdata2,
        .id_allowin, .rf_raddr1, .rf_raddr2,
        .flush, .pc_real,
        .id_to_ex
);

execute_stage u_execute (
        .clk, .rst,
        .id_to_ex, .ex_allowin, .ex_fwd, .ex_to_mem
);

memory_stage u_memory (
        .clk, .rst,
        .ex_to_mem, .mem_fwd, .mem_done, .done_pc, .load_data, .mem_to_wb
);

// writeback lives in the register file
register_file u_regfile (
        .clk,
        .raddr1         (rf_raddr1),
        .raddr2         (rf_raddr2),
        .rdata1         (rf_rdata1),
        .rdata2         (rf_rdata2),
        .wb             (mem_to_wb),
        .retire_valid,
        .retire
);

endmodule

`default_nettype wire

//--- sim/la_core_tb.sv
`include "la_core_params.svh"
`default_nettype none

module la_core_tb import la_core_pkg::*; ();

localparam int PROG_AW = 6;
localparam int PROG_WORDS = 1 << PROG_AW;
localparam int PROG_INSTS = 39;
localparam int WATCHDOG_CYCLES = 16 + 40 * PROG_INSTS;

// opcode fields of the LoongArch subset
localparam logic [16:0] OP_ADD_W  = 17'h00020;
localparam logic [16:0] OP_SUB_W  = 17'h00022;
localparam logic [16:0] OP_SLT    = 17'h00024;
localparam logic [16:0] OP_SLTU   = 17'h00025;
localparam logic [16:0] OP_NOR    = 17'h00028;
localparam logic [16:0] OP_AND    = 17'h00029;
localparam logic [16:0] OP_OR     = 17'h0002a;
localparam logic [16:0] OP_XOR    = 17'h0002b;
localparam logic [16:0] OP_SLLI_W = 17'h00081;
localparam logic [16:0] OP_SRLI_W = 17'h00089;
localparam logic [16:0] OP_SRAI_W = 17'h00091;
localparam logic [9:0]  OP_ADDI_W = 10'h00a;
localparam logic [9:0]  OP_LD_W   = 10'h0a2;
localparam logic [9:0]  OP_ST_W   = 10'h0a6;
localparam logic [5:0]  OP_JIRL   = 6'h13;
localparam logic [5:0]  OP_B      = 6'h14;
localparam logic [5:0]  OP_BL     = 6'h15;
localparam logic [5:0]  OP_BEQ    = 6'h16;
localparam logic [5:0]  OP_BNE    = 6'h17;

typedef struct packed {
        logic [31:0]    pc;
        logic           we;
        logic [4:0]     dest;
        logic [31:0]    data;
        logic [2:0]     grp;
} ret_entry_t;

logic           clk;
logic           rst;
logic [31:0]    inst_rdata;
wire  [31:0]    inst_addr;
wire            retire_valid;
wire retire_t   retire;

logic [31:0]    imem [PROG_WORDS];
ret_entry_t     ret_table [$];
int             ret_idx = 0;
int             reset_edges = 0;
int             errors = 0;
int             grp_checks [6];
int             grp_errs [6];

la_core_top UUT (
        .clk            (clk),
        .rst            (rst),
        .inst_addr      (inst_addr),
        .inst_rdata     (inst_rdata),
        .retire_valid   (retire_valid),
        .retire         (retire)
);

// ----------------------------------------------------------------------
// instruction encoders
// ----------------------------------------------------------------------
function automatic logic [31:0] three_reg(input logic [16:0] op, input int rd, rj, rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};        // shifts put ui5 in the rk slot
endfunction

function automatic logic [31:0] reg_imm12(input logic [9:0] op, input int rd, rj, imm);
        return {op, imm[11:0], rj[4:0], rd[4:0]};
endfunction

function automatic logic [31:0] upper_imm(input int rd, input int si20);
        return {7'h0a, si20[19:0], rd[4:0]};
endfunction

// offsets are in words
function automatic logic [31:0] offs16_form(input logic [5:0] op, input int rj, rd, offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
endfunction

function automatic logic [31:0] offs26_form(input logic [5:0] op, input int offs);
        return {op, offs[15:0], offs[25:16]};
endfunction

// unused words hold an addi.w to r0 whose immediate folds in the whole address
function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [11:0] h;
        h = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
        return {OP_ADDI_W, h, 5'd0, 5'd0};
endfunction

function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0]            offs;
        logic [PROG_AW-1:0]     widx;
        offs = addr - `LA_RESET_PC;
        widx = offs[PROG_AW+1:2];
        if (offs < 32'(PROG_WORDS * 4)) begin
                return imem[widx];
        end
        return fill_word(addr);
endfunction

task automatic load_program();
        for (int k = 0; k < PROG_WORDS; k++) begin
                imem[k[PROG_AW-1:0]] = fill_word(`LA_RESET_PC + 32'(k) * 32'd4);
        end
        imem[0]  = upper_imm(4, 'h12345);
        imem[1]  = reg_imm12(OP_ADDI_W, 5, 0, 'h678);
        imem[2]  = three_reg(OP_OR, 6, 4, 5);
        imem[3]  = reg_imm12(OP_ADDI_W, 7, 0, -3);
        imem[4]  = three_reg(OP_ADD_W, 8, 6, 7);
        imem[5]  = three_reg(OP_SUB_W, 9, 7, 5);
        imem[6]  = three_reg(OP_SLT, 10, 7, 5);
        imem[7]  = three_reg(OP_SLTU, 11, 7, 5);
        imem[8]  = three_reg(OP_AND, 12, 6, 9);
        imem[9]  = three_reg(OP_NOR, 13, 5, 7);
        imem[10] = three_reg(OP_XOR, 14, 6, 4);
        imem[11] = three_reg(OP_SLLI_W, 15, 5, 4);
        imem[12] = three_reg(OP_SRLI_W, 16, 7, 28);
        imem[13] = three_reg(OP_SRAI_W, 17, 9, 4);
        imem[14] = reg_imm12(OP_ADDI_W, 0, 5, 1);
        imem[15] = three_reg(OP_ADD_W, 18, 0, 5);
        imem[16] = reg_imm12(OP_ADDI_W, 19, 18, 1);
        imem[17] = reg_imm12(OP_ADDI_W, 20, 0, 7);
        imem[18] = three_reg(OP_ADD_W, 21, 19, 20);
        imem[19] = reg_imm12(OP_ADDI_W, 22, 0, 'h40);
        imem[20] = reg_imm12(OP_ST_W, 21, 22, 0);
        imem[21] = reg_imm12(OP_ST_W, 6, 22, 4);
        imem[22] = reg_imm12(OP_LD_W, 23, 22, 0);
        imem[23] = three_reg(OP_ADD_W, 24, 23, 20);    // load-use pair
        imem[24] = reg_imm12(OP_LD_W, 25, 22, 4);
        imem[25] = reg_imm12(OP_ADDI_W, 26, 0, 1);
        imem[26] = three_reg(OP_XOR, 27, 25, 26);
        imem[27] = offs16_form(OP_BEQ, 5, 18, 2);
        imem[28] = reg_imm12(OP_ADDI_W, 28, 0, 'h111);
        imem[29] = offs16_form(OP_BNE, 5, 18, 2);
        imem[30] = reg_imm12(OP_ADDI_W, 28, 0, 'h222);
        imem[31] = offs26_form(OP_B, 2);
        imem[32] = reg_imm12(OP_ADDI_W, 29, 0, 'h333);
        imem[33] = offs26_form(OP_BL, 3);
        imem[34] = reg_imm12(OP_ADDI_W, 30, 0, 'h444);  // jirl returns here
        imem[35] = offs26_form(OP_B, 0);               // park in a self loop
        imem[36] = reg_imm12(OP_ADDI_W, 2, 1, 8);
        imem[37] = offs16_form(OP_JIRL, 2, 3, -2);
        imem[38] = reg_imm12(OP_ADDI_W, 31, 0, 'h555);
endtask

// ----------------------------------------------------------------------
// expected retire stream, in program order
// ----------------------------------------------------------------------
task automatic add_retire(input int idx, input logic we, input int dest,
                          input logic [31:0] data, input int grp);
        ret_table.push_back('{pc: `LA_RESET_PC + 32'(idx) * 32'd4, we: we,
                              dest: dest[4:0], data: data, grp: grp[2:0]});
endtask

task automatic build_retire_table();
        add_retire(0,  1'b1, 4,  32'h1234_5000, 0);
        add_retire(1,  1'b1, 5,  32'h0000_0678, 1);
        add_retire(2,  1'b1, 6,  32'h1234_5678, 1);
        add_retire(3,  1'b1, 7,  32'hffff_fffd, 1);
        add_retire(4,  1'b1, 8,  32'h1234_5675, 1);
        add_retire(5,  1'b1, 9,  32'hffff_f985, 1);
        add_retire(6,  1'b1, 10, 32'h0000_0001, 1);
        add_retire(7,  1'b1, 11, 32'h0000_0000, 1);
        add_retire(8,  1'b1, 12, 32'h1234_5000, 1);
        add_retire(9,  1'b1, 13, 32'h0000_0002, 1);
        add_retire(10, 1'b1, 14, 32'h0000_0678, 1);
        add_retire(11, 1'b1, 15, 32'h0000_6780, 1);
        add_retire(12, 1'b1, 16, 32'h0000_000f, 1);
        add_retire(13, 1'b1, 17, 32'hffff_ff98, 1);
        add_retire(14, 1'b1, 0,  32'h0000_0679, 1);    // r0 keeps reading zero
        add_retire(15, 1'b1, 18, 32'h0000_0678, 1);
        add_retire(16, 1'b1, 19, 32'h0000_0679, 2);
        add_retire(17, 1'b1, 20, 32'h0000_0007, 2);
        add_retire(18, 1'b1, 21, 32'h0000_0680, 2);
        add_retire(19, 1'b1, 22, 32'h0000_0040, 3);
        add_retire(20, 1'b0, 0,  32'd0, 3);
        add_retire(21, 1'b0, 0,  32'd0, 3);
        add_retire(22, 1'b1, 23, 32'h0000_0680, 3);
        add_retire(23, 1'b1, 24, 32'h0000_0687, 3);
        add_retire(24, 1'b1, 25, 32'h1234_5678, 3);
        add_retire(25, 1'b1, 26, 32'h0000_0001, 3);
        add_retire(26, 1'b1, 27, 32'h1234_5679, 3);
        add_retire(27, 1'b0, 0,  32'd0, 4);
        add_retire(29, 1'b0, 0,  32'd0, 4);
        add_retire(30, 1'b1, 28, 32'h0000_0222, 4);
        add_retire(31, 1'b0, 0,  32'd0, 4);
        add_retire(33, 1'b1, 1,  `LA_RESET_PC + 32'h88, 5);
        add_retire(36, 1'b1, 2,  `LA_RESET_PC + 32'h90, 5);
        add_retire(37, 1'b1, 3,  `LA_RESET_PC + 32'h98, 5);
        add_retire(34, 1'b1, 30, 32'h0000_0444, 5);
        add_retire(35, 1'b0, 0,  32'd0, 5);
endtask

function automatic string group_label(input logic [2:0] g);
        case (g)
                3'd0:    return "reset";
                3'd1:    return "alu and immediates";
                3'd2:    return "forwarding";
                3'd3:    return "loads and stores";
                3'd4:    return "branches";
                default: return "links";
        endcase
endfunction

task automatic report_mismatch(input string name, input logic [31:0] actual,
                               input logic [31:0] expected, input logic [2:0] g);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
        errors++;
        grp_errs[g]++;
endtask

task automatic check_retire();
        ret_entry_t     e;
        logic [2:0]     g;
        e = ret_table[ret_idx];
        g = e.grp;
        grp_checks[g]++;
        assert (retire.pc == e.pc) else report_mismatch("retire.pc", retire.pc, e.pc, g);
        assert (retire.we == e.we)
        else report_mismatch("retire.we", 32'(retire.we), 32'(e.we), g);
        if (e.we) begin
                assert (retire.dest == e.dest)
                else report_mismatch("retire.dest", 32'(retire.dest), 32'(e.dest), g);
                assert (retire.data == e.data)
                else report_mismatch("retire.data", retire.data, e.data, g);
        end
        ret_idx++;
        if (ret_idx == ret_table.size() || ret_table[ret_idx].grp != g) begin
                $display("test %s: %0d checks, %0d errors", group_label(g),
                         grp_checks[g], grp_errs[g]);
        end
endtask

// ----------------------------------------------------------------------
// clock, instruction memory, checker and watchdog
// ----------------------------------------------------------------------
always #5 clk = ~clk;

always @(posedge clk) begin
        #1;
        inst_rdata = fetch_word(inst_addr);
end

// outputs settle half a cycle before the next edge
always @(negedge clk) begin
        if (rst) begin
                reset_edges++;
                if (reset_edges >= 2) begin     // the retire flop needs two edges to clear
                        grp_checks[0]++;
                        assert (retire_valid == 1'b0)
                        else report_mismatch("retire_valid", 32'(retire_valid), 32'd0, 3'd0);
                end
        end else if (retire_valid && ret_idx < ret_table.size()) begin
                check_retire();
        end
end

initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog: the retire stream stalled after %0d of %0d retires",
                 ret_idx, ret_table.size());
        $display("Simulation finished: FAIL");
        $finish;
end

initial begin
        clk = 1'b0;
        rst = 1'b1;
        inst_rdata = 32'd0;
        for (int k = 0; k < 6; k++) begin
                grp_checks[k] = 0;
                grp_errs[k] = 0;
        end
        load_program();
        build_retire_table();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        while (ret_idx < ret_table.size()) begin
                @(negedge clk);
        end
        $display("%0d retires checked, %0d reset cycles checked, %0d errors",
                 ret_idx, grp_checks[0] - 1, errors);
        if (errors == 0) begin
                $display("Simulation finished: PASS");
        end else begin
                $display("Simulation finished: FAIL");
        end
        $finish;
end

endmodule

`default_nettype wire

//--- la_core.f
+incdir+design
design/la_core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/register_file.sv
design/la_core_top.sv
sim/la_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module la_core_tb -f la_core.f -o la_core_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

out=$(./obj_dir/la_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
        exit 0
fi
exit 1
